//--- source/rv32i_pkg.sv
// ====================
// RV32I ISA definitions
// Word type, major opcodes, funct codes, instruction formats
// ====================
package rv32i_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011
  } opcode_t;

  // funct3 of the integer ALU group, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_ALT = 7'b0100000;  // SUB and SRA(I)

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;      // Sign bit, set for backward branches
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } j_fmt_t;

  // One fetched word, read through whichever format applies
  typedef union packed {
    word_t  word;
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  // Immediate extraction, sign extended to a full word
  function automatic word_t imm_i(instr_u instr);
    return {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
  endfunction

  function automatic word_t imm_s(instr_u instr);
    return {{20{instr.s_fmt.imm11_5[6]}}, instr.s_fmt.imm11_5, instr.s_fmt.imm4_0};
  endfunction

  function automatic word_t imm_b(instr_u instr);
    return {{20{instr.b_fmt.imm12}}, instr.b_fmt.imm11, instr.b_fmt.imm10_5,
            instr.b_fmt.imm4_1, 1'b0};
  endfunction

  function automatic word_t imm_u(instr_u instr);
    return {instr.u_fmt.imm31_12, 12'h000};
  endfunction

  function automatic word_t imm_j(instr_u instr);
    return {{12{instr.j_fmt.imm20}}, instr.j_fmt.imm19_12, instr.j_fmt.imm11,
            instr.j_fmt.imm10_1, 1'b0};
  endfunction

endpackage

//--- source/pipe_pkg.sv
// ====================
// Pipeline definitions
// Stage register, control bundle and memory request types
// ====================
package pipe_pkg;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_t;

  // Encoded as the branch funct3 so decode is a plain cast
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_type_t;

  typedef enum logic {A_RS1, A_PC} alu_a_sel_t;
  typedef enum logic {B_RS2, B_IMM} alu_b_sel_t;
  typedef enum logic [1:0] {W_LOAD, W_PC4, W_IMM, W_ALU} w_sel_t;
  typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} size_t;  // funct3[1:0]

  typedef struct packed {
    logic               valid;
    rv32i_pkg::word_t   pc;
    rv32i_pkg::word_t   pc4;
    rv32i_pkg::instr_u  instr;
    logic               prediction;  // Fetch guessed taken
    logic               halt;        // All-zero marker word
  } fetch_ex_t;

  typedef struct packed {
    alu_op_t          alu_op;
    alu_a_sel_t       alu_a_sel;
    alu_b_sel_t       alu_b_sel;
    w_sel_t           w_sel;
    logic             wen;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    rv32i_pkg::word_t imm;
    logic             branch;
    branch_type_t     branch_type;
    logic             jump;
    logic             j_sel;       // 1 for JAL, 0 for JALR
    logic             dren;
    logic             dwen;
    size_t            size;
    logic             load_unsigned;
  } ctrl_t;

  typedef struct packed {
    logic             ren;
    logic             wen;
    logic [3:0]       byte_en;
    rv32i_pkg::word_t addr;
    rv32i_pkg::word_t wdata;
  } dmem_req_t;

  typedef struct packed {
    logic             mispredict;
    rv32i_pkg::word_t target;
  } redirect_t;

endpackage

//--- source/alu.sv
// ====================
// Integer ALU
// All ten RV32I register operations
// ====================
module alu (
  input  pipe_pkg::alu_op_t alu_op,
  input  rv32i_pkg::word_t  port_a,
  input  rv32i_pkg::word_t  port_b,
  output rv32i_pkg::word_t  port_out
);

  logic [4:0] shamt;

  assign shamt = port_b[4:0];  // Shifts only look at 5 bits

  always_comb begin
    case (alu_op)
      pipe_pkg::ADD:  port_out = port_a + port_b;
      pipe_pkg::SUB:  port_out = port_a - port_b;
      pipe_pkg::SLL:  port_out = port_a << shamt;
      pipe_pkg::SLT:  port_out = {31'd0, $signed(port_a) < $signed(port_b)};
      pipe_pkg::SLTU: port_out = {31'd0, port_a < port_b};
      pipe_pkg::XOR:  port_out = port_a ^ port_b;
      pipe_pkg::SRL:  port_out = port_a >> shamt;
      pipe_pkg::SRA:  port_out = $signed(port_a) >>> shamt;  // Keeps sign
      pipe_pkg::OR:   port_out = port_a | port_b;
      pipe_pkg::AND:  port_out = port_a & port_b;
      default:        port_out = '0;
    endcase
  end

endmodule

//--- source/control_unit.sv
// ====================
// Control unit
// Decodes one RV32I word into the control bundle
// ====================
module control_unit (
  input  rv32i_pkg::instr_u instr,
  output pipe_pkg::ctrl_t   ctrl
);

  // ALU operation from funct3, alt selects SUB or SRA
  function automatic pipe_pkg::alu_op_t alu_decode(logic [2:0] funct3, logic alt);
    pipe_pkg::alu_op_t op;
    case (funct3)
      rv32i_pkg::F3_ADD_SUB: op = alt ? pipe_pkg::SUB : pipe_pkg::ADD;
      rv32i_pkg::F3_SLL:     op = pipe_pkg::SLL;
      rv32i_pkg::F3_SLT:     op = pipe_pkg::SLT;
      rv32i_pkg::F3_SLTU:    op = pipe_pkg::SLTU;
      rv32i_pkg::F3_XOR:     op = pipe_pkg::XOR;
      rv32i_pkg::F3_SRL_SRA: op = alt ? pipe_pkg::SRA : pipe_pkg::SRL;
      rv32i_pkg::F3_OR:      op = pipe_pkg::OR;
      default:               op = pipe_pkg::AND;
    endcase
    return op;
  endfunction

  logic alt;
  logic is_shift;

  assign alt      = instr.r_fmt.funct7 == rv32i_pkg::F7_ALT;
  assign is_shift = instr.r_fmt.funct3 == rv32i_pkg::F3_SLL ||
                    instr.r_fmt.funct3 == rv32i_pkg::F3_SRL_SRA;

  always_comb begin
    ctrl               = '0;  // Unknown words decode to a no-op
    ctrl.alu_op        = pipe_pkg::ADD;
    ctrl.alu_a_sel     = pipe_pkg::A_RS1;
    ctrl.alu_b_sel     = pipe_pkg::B_IMM;
    ctrl.w_sel         = pipe_pkg::W_ALU;
    ctrl.rd            = instr.r_fmt.rd;
    ctrl.rs1           = instr.r_fmt.rs1;
    ctrl.rs2           = instr.r_fmt.rs2;
    ctrl.branch_type   = pipe_pkg::branch_type_t'(instr.b_fmt.funct3);
    ctrl.size          = pipe_pkg::size_t'(instr.i_fmt.funct3[1:0]);
    ctrl.load_unsigned = instr.i_fmt.funct3[2];

    case (instr.r_fmt.opcode)
      rv32i_pkg::LUI: begin
        ctrl.wen   = 1'b1;
        ctrl.w_sel = pipe_pkg::W_IMM;
        ctrl.imm   = rv32i_pkg::imm_u(instr);
      end
      rv32i_pkg::AUIPC: begin
        ctrl.wen       = 1'b1;
        ctrl.alu_a_sel = pipe_pkg::A_PC;  // pc + upper immediate
        ctrl.imm       = rv32i_pkg::imm_u(instr);
      end
      rv32i_pkg::JAL: begin
        ctrl.wen   = 1'b1;
        ctrl.w_sel = pipe_pkg::W_PC4;  // Link
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b1;
        ctrl.imm   = rv32i_pkg::imm_j(instr);
      end
      rv32i_pkg::JALR: begin
        ctrl.wen   = 1'b1;
        ctrl.w_sel = pipe_pkg::W_PC4;
        ctrl.jump  = 1'b1;
        ctrl.imm   = rv32i_pkg::imm_i(instr);
      end
      rv32i_pkg::BRANCH: begin
        ctrl.branch = 1'b1;
        ctrl.imm    = rv32i_pkg::imm_b(instr);
      end
      rv32i_pkg::LOAD: begin
        ctrl.wen   = 1'b1;
        ctrl.dren  = 1'b1;
        ctrl.w_sel = pipe_pkg::W_LOAD;
        ctrl.imm   = rv32i_pkg::imm_i(instr);  // Address is rs1 + imm
      end
      rv32i_pkg::STORE: begin
        ctrl.dwen = 1'b1;
        ctrl.imm  = rv32i_pkg::imm_s(instr);
      end
      rv32i_pkg::OP_IMM: begin
        ctrl.wen = 1'b1;
        // SUB has no immediate form, alt only counts for shifts
        ctrl.alu_op = alu_decode(instr.i_fmt.funct3, alt && is_shift);
        if (is_shift) ctrl.imm = {27'd0, instr.r_fmt.rs2};  // shamt
        else ctrl.imm = rv32i_pkg::imm_i(instr);
      end
      rv32i_pkg::OP: begin
        ctrl.wen       = 1'b1;
        ctrl.alu_b_sel = pipe_pkg::B_RS2;
        ctrl.alu_op    = alu_decode(instr.r_fmt.funct3, alt);
      end
      default: ;
    endcase
  end

endmodule

//--- source/rv32i_reg_file.sv
// ====================
// Integer register file
// 32 x 32, two reads, one write, x0 fixed at zero
// ====================
module rv32i_reg_file (
  input  logic             CLK,
  input  logic             reset,
  input  logic [4:0]       rs1,
  input  logic [4:0]       rs2,
  input  logic [4:0]       rd,
  input  rv32i_pkg::word_t w_data,
  input  logic             wen,
  output rv32i_pkg::word_t rs1_data,
  output rv32i_pkg::word_t rs2_data
);

  rv32i_pkg::word_t regs [32];

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wen && rd != 5'd0) begin  // x0 never written
      regs[rd] <= w_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

//--- source/fetch_stage.sv
// ====================
// Fetch stage
// PC register, static branch prediction, fetch/execute register
// ====================
module fetch_stage #(
  parameter rv32i_pkg::word_t RESET_PC = '0
) (
  input  logic                CLK,
  input  logic                reset,
  input  rv32i_pkg::word_t    imem_rdata,
  input  pipe_pkg::redirect_t redirect,
  input  logic                mem_stall,
  output rv32i_pkg::word_t    imem_addr,
  output pipe_pkg::fetch_ex_t fex
);

  rv32i_pkg::word_t    pc;
  rv32i_pkg::word_t    pc4;
  rv32i_pkg::word_t    pc_next;
  rv32i_pkg::instr_u   instr;
  pipe_pkg::fetch_ex_t fex_next;
  logic                is_branch;
  logic                is_jal;
  logic                predict_taken;
  logic                halt_word;
  logic                stop;

  assign imem_addr = pc;
  assign instr     = imem_rdata;  // Memory answers in the same cycle
  assign pc4       = pc + 32'd4;

  // Backward branches taken, forward ones not; JAL always followed
  assign is_branch     = instr.b_fmt.opcode == rv32i_pkg::BRANCH;
  assign is_jal        = instr.j_fmt.opcode == rv32i_pkg::JAL;
  assign predict_taken = (is_branch && instr.b_fmt.imm12) || is_jal;
  assign halt_word     = instr.word == '0;

  always_comb begin
    if (halt_word) pc_next = pc;  // Park on the marker
    else if (predict_taken && is_jal) pc_next = pc + rv32i_pkg::imm_j(instr);
    else if (predict_taken) pc_next = pc + rv32i_pkg::imm_b(instr);
    else pc_next = pc4;
  end

  always_comb begin
    fex_next.valid      = 1'b1;
    fex_next.pc         = pc;
    fex_next.pc4        = pc4;
    fex_next.instr      = instr;
    fex_next.prediction = predict_taken;
    fex_next.halt       = halt_word;
  end

  // Marker reached execute, nothing more is fetched
  assign stop = fex.valid && fex.halt;

  always_ff @(posedge CLK) begin
    if (reset) begin
      pc        <= RESET_PC;
      fex.valid <= 1'b0;
      fex.halt  <= 1'b0;
    end else if (!mem_stall) begin  // Busy data port freezes everything
      if (redirect.mispredict) begin
        pc        <= redirect.target;
        fex.valid <= 1'b0;  // Flush the wrong-path slot
      end else if (!stop) begin
        pc  <= pc_next;
        fex <= fex_next;
      end
    end
  end

endmodule

//--- source/execute_stage.sv
// ====================
// Execute stage
// Decode, register file, ALU, branch resolution, data port
// ====================
module execute_stage (
  input  logic                CLK,
  input  logic                reset,
  input  pipe_pkg::fetch_ex_t fex,
  input  rv32i_pkg::word_t    dmem_rdata,
  input  logic                dmem_busy,
  output pipe_pkg::dmem_req_t dmem_req,
  output pipe_pkg::redirect_t redirect,
  output logic                mem_stall,
  output logic                halt
);

  pipe_pkg::ctrl_t  ctrl;
  rv32i_pkg::word_t rs1_data;
  rv32i_pkg::word_t rs2_data;
  rv32i_pkg::word_t w_data;
  rv32i_pkg::word_t port_a;
  rv32i_pkg::word_t port_b;
  rv32i_pkg::word_t alu_out;
  rv32i_pkg::word_t jump_addr;
  rv32i_pkg::word_t load_lane;
  rv32i_pkg::word_t load_data;
  logic [1:0]       offset;
  logic [3:0]       byte_en;
  logic             taken;
  logic             access;

  control_unit i_cu (
    .instr(fex.instr),
    .ctrl (ctrl)
  );

  // Write lands at the edge ending the cycle, held back while stalled
  rv32i_reg_file i_rf (
    .CLK     (CLK),
    .reset   (reset),
    .rs1     (ctrl.rs1),
    .rs2     (ctrl.rs2),
    .rd      (ctrl.rd),
    .w_data  (w_data),
    .wen     (fex.valid && ctrl.wen && !mem_stall),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  assign port_a = (ctrl.alu_a_sel == pipe_pkg::A_PC) ? fex.pc : rs1_data;
  assign port_b = (ctrl.alu_b_sel == pipe_pkg::B_IMM) ? ctrl.imm : rs2_data;

  alu i_alu (
    .alu_op  (ctrl.alu_op),
    .port_a  (port_a),
    .port_b  (port_b),
    .port_out(alu_out)
  );

  always_comb begin
    case (ctrl.branch_type)
      pipe_pkg::BEQ:  taken = rs1_data == rs2_data;
      pipe_pkg::BNE:  taken = rs1_data != rs2_data;
      pipe_pkg::BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
      pipe_pkg::BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
      pipe_pkg::BLTU: taken = rs1_data < rs2_data;
      default:        taken = rs1_data >= rs2_data;  // BGEU
    endcase
  end

  // JAL is pc relative, JALR drops bit 0 of rs1 + imm
  assign jump_addr = ctrl.j_sel ? fex.pc + ctrl.imm : (rs1_data + ctrl.imm) & ~32'd1;

  // Jumps always redirect, branches only when the guess was wrong
  assign redirect.mispredict = fex.valid &&
                               (ctrl.jump || (ctrl.branch && fex.prediction != taken));
  always_comb begin
    if (ctrl.jump) redirect.target = jump_addr;
    else if (taken) redirect.target = fex.pc + ctrl.imm;
    else redirect.target = fex.pc4;
  end

  // Byte lanes follow the low address bits, little-endian
  assign offset = alu_out[1:0];
  always_comb begin
    case (ctrl.size)
      pipe_pkg::SIZE_BYTE: byte_en = 4'b0001 << offset;
      pipe_pkg::SIZE_HALF: byte_en = 4'b0011 << offset;
      default:             byte_en = 4'b1111;
    endcase
  end

  assign access           = fex.valid && (ctrl.dren || ctrl.dwen);
  assign dmem_req.ren     = fex.valid && ctrl.dren;
  assign dmem_req.wen     = fex.valid && ctrl.dwen;
  assign dmem_req.byte_en = access ? byte_en : 4'b0000;
  assign dmem_req.addr    = alu_out;
  assign dmem_req.wdata   = rs2_data << {offset, 3'b000};
  assign mem_stall        = access && dmem_busy;  // Held until busy falls

  // Pull the addressed lane down, then extend
  assign load_lane = dmem_rdata >> {offset, 3'b000};
  always_comb begin
    case (ctrl.size)
      pipe_pkg::SIZE_BYTE:
        load_data = {{24{load_lane[7] && !ctrl.load_unsigned}}, load_lane[7:0]};
      pipe_pkg::SIZE_HALF:
        load_data = {{16{load_lane[15] && !ctrl.load_unsigned}}, load_lane[15:0]};
      default: load_data = dmem_rdata;
    endcase
  end

  always_comb begin
    case (ctrl.w_sel)
      pipe_pkg::W_LOAD: w_data = load_data;
      pipe_pkg::W_PC4:  w_data = fex.pc4;
      pipe_pkg::W_IMM:  w_data = ctrl.imm;  // LUI
      default:          w_data = alu_out;
    endcase
  end

  assign halt = fex.valid && fex.halt;

endmodule

//--- source/rv32i_core.sv
// ====================
// Two-stage RV32I core
// Fetch and execute joined to the memory ports
// ====================
module rv32i_core #(
  parameter rv32i_pkg::word_t RESET_PC = '0
) (
  input  logic                CLK,
  input  logic                reset,
  input  rv32i_pkg::word_t    imem_rdata,
  input  rv32i_pkg::word_t    dmem_rdata,
  input  logic                dmem_busy,
  output rv32i_pkg::word_t    imem_addr,
  output pipe_pkg::dmem_req_t dmem_req,
  output logic                halt
);

  pipe_pkg::fetch_ex_t fex;       // Stage register
  pipe_pkg::redirect_t redirect;  // Execute back to fetch
  logic                mem_stall;

  fetch_stage #(
    .RESET_PC(RESET_PC)
  ) i_fetch (
    .CLK       (CLK),
    .reset     (reset),
    .imem_rdata(imem_rdata),
    .redirect  (redirect),
    .mem_stall (mem_stall),
    .imem_addr (imem_addr),
    .fex       (fex)
  );

  execute_stage i_execute (
    .CLK       (CLK),
    .reset     (reset),
    .fex       (fex),
    .dmem_rdata(dmem_rdata),
    .dmem_busy (dmem_busy),
    .dmem_req  (dmem_req),
    .redirect  (redirect),
    .mem_stall (mem_stall),
    .halt      (halt)
  );

endmodule

//--- tb/tb_core.sv
// ====================
// Testbench for the RV32I core
// Memory models, random data-port stalls, store checking
// ====================
module tb_core;

  localparam int NUM_REC = 13;
  localparam rv32i_pkg::word_t START_PC = 32'h0;
  localparam rv32i_pkg::word_t HALT_PC  = 32'h90;  // Halt marker in the program

  logic                CLK;
  logic                reset;
  rv32i_pkg::word_t    imem_addr;
  rv32i_pkg::word_t    imem_rdata;
  rv32i_pkg::word_t    dmem_rdata;
  logic                dmem_busy;
  pipe_pkg::dmem_req_t dmem_req;
  logic                halt;

  rv32i_pkg::word_t imem [64];
  rv32i_pkg::word_t dmem [64];

  // Expected stores in program order
  rv32i_pkg::word_t exp_addr [NUM_REC];
  rv32i_pkg::word_t exp_data [NUM_REC];
  logic [3:0]       exp_be   [NUM_REC];

  integer              seed;
  int                  wait_cnt;  // Busy cycles left for the current access
  int                  rec_idx;
  int                  cycles;
  logic                active;
  logic                wr_fire;
  logic                was_stalled;
  logic                halt_seen;
  pipe_pkg::dmem_req_t prev_req;

  rv32i_core #(
    .RESET_PC(START_PC)
  ) i_dut (
    .CLK       (CLK),
    .reset     (reset),
    .imem_rdata(imem_rdata),
    .dmem_rdata(dmem_rdata),
    .dmem_busy (dmem_busy),
    .imem_addr (imem_addr),
    .dmem_req  (dmem_req),
    .halt      (halt)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  assign imem_rdata = imem[imem_addr[7:2]];
  assign dmem_rdata = dmem[dmem_req.addr[7:2]];
  assign active     = dmem_req.ren || dmem_req.wen;
  assign dmem_busy  = active && (wait_cnt != 0);
  assign wr_fire    = dmem_req.wen && !dmem_busy;

  function automatic rv32i_pkg::word_t lane_mask(logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  task automatic expect_store(int idx, rv32i_pkg::word_t addr, rv32i_pkg::word_t data,
                              logic [3:0] be);
    exp_addr[idx] = addr;
    exp_data[idx] = data;
    exp_be[idx]   = be;
  endtask

  task automatic report_mismatch(string name, rv32i_pkg::word_t exp, rv32i_pkg::word_t got);
    $display("Fail t=%0t %s expected %h actual %h", $time, name, exp, got);
    $display("TEST FAIL");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(string why);
    $display("%s at t=%0t", why, $time);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  // Wait count for the next access is reloaded as each one completes
  always @(posedge CLK) begin
    if (reset) wait_cnt <= int'($unsigned($random(seed)) % 3);
    else if (active && dmem_busy) wait_cnt <= wait_cnt - 1;
    else if (active) wait_cnt <= int'($unsigned($random(seed)) % 3);
  end

  // Data memory writes only the enabled lanes
  always @(posedge CLK) begin
    if (!reset && wr_fire) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_req.byte_en[b]) dmem[dmem_req.addr[7:2]][b*8 +: 8] <= dmem_req.wdata[b*8 +: 8];
      end
    end
  end

  // Each store record is matched once at completion
  always @(posedge CLK) begin
    if (reset) begin
      rec_idx <= 0;
    end else if (wr_fire) begin
      assert (rec_idx < NUM_REC) else abort_run("Store issued beyond the expected list");
      if (rec_idx < NUM_REC) begin
        assert (dmem_req.addr == exp_addr[rec_idx])
          else report_mismatch("dmem_req.addr", exp_addr[rec_idx], dmem_req.addr);
        assert (dmem_req.byte_en == exp_be[rec_idx])
          else report_mismatch("dmem_req.byte_en", 32'(exp_be[rec_idx]),
                               32'(dmem_req.byte_en));
        assert ((dmem_req.wdata & lane_mask(exp_be[rec_idx])) == exp_data[rec_idx])
          else report_mismatch("dmem_req.wdata", exp_data[rec_idx],
                               dmem_req.wdata & lane_mask(exp_be[rec_idx]));
      end
      rec_idx <= rec_idx + 1;
    end
  end

  // Request frozen while busy and quiet after halt
  always @(posedge CLK) begin
    if (reset) begin
      was_stalled <= 1'b0;
      halt_seen   <= 1'b0;
    end else begin
      if (was_stalled) begin
        assert (dmem_req.addr == prev_req.addr)
          else report_mismatch("dmem_req.addr", prev_req.addr, dmem_req.addr);
        assert (dmem_req.wdata == prev_req.wdata)
          else report_mismatch("dmem_req.wdata", prev_req.wdata, dmem_req.wdata);
        assert ({dmem_req.ren, dmem_req.wen, dmem_req.byte_en} ==
                {prev_req.ren, prev_req.wen, prev_req.byte_en})
          else report_mismatch("dmem_req.ren/wen/byte_en",
                               32'({prev_req.ren, prev_req.wen, prev_req.byte_en}),
                               32'({dmem_req.ren, dmem_req.wen, dmem_req.byte_en}));
      end
      if (halt) begin
        assert (rec_idx == NUM_REC) else abort_run("Halt raised before all stores completed");
      end
      if (halt || halt_seen) begin
        assert (!active) else abort_run("Data request issued after halt");
        assert (imem_addr == HALT_PC)  // Fetch parks on the marker
          else report_mismatch("imem_addr", HALT_PC, imem_addr);
      end
      was_stalled <= active && dmem_busy;
      prev_req    <= dmem_req;
      halt_seen   <= halt_seen || halt;
    end
  end

  initial begin
    seed = 32'h6ee1a2b4;
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;
      dmem[i] <= '0;
    end
    $readmemh("tb/program.hex", imem);

    expect_store(0, 32'd0, 32'd13, 4'b1111);              // 10 - (-3)
    expect_store(1, 32'd4, 32'hfffffffe, 4'b1111);        // -3 >>> 1
    expect_store(2, 32'd8, 32'h12345001, 4'b1111);        // lui ^ slt
    expect_store(3, 32'd12, 32'h00001028, 4'b1111);       // auipc at 28
    expect_store(4, 32'd16, 32'd55, 4'b1111);             // 1 + .. + 10
    expect_store(5, 32'd20, 32'd1, 4'b1111);
    expect_store(6, 32'd24, 32'h0000005c, 4'b1111);       // jal link
    expect_store(7, 32'd28, 32'h00000068, 4'b1111);       // jalr link
    expect_store(8, 32'd33, 32'h0000fd00, 4'b0010);       // sb lane 1
    expect_store(9, 32'd38, 32'h50010000, 4'b1100);       // sh upper half
    expect_store(10, 32'd40, 32'hfffffffd, 4'b1111);      // lb
    expect_store(11, 32'd44, 32'h000000fd, 4'b1111);      // lbu
    expect_store(12, 32'd48, 32'h00005001, 4'b1111);      // lh

    reset = 1'b1;
    repeat (8) @(posedge CLK);
    reset <= 1'b0;

    @(posedge CLK);  // First cycle out of reset
    assert (imem_addr == START_PC) else report_mismatch("imem_addr", START_PC, imem_addr);
    assert (!halt && !active) else abort_run("Halt or data request active out of reset");

    cycles = 0;
    while (!halt) begin
      @(posedge CLK);
      cycles++;
      if (cycles > 2000) abort_run("Timeout waiting for halt");
    end
    repeat (10) @(posedge CLK);  // Port must stay idle after halt

    if (rec_idx == NUM_REC) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("Only %0d of %0d stores seen", rec_idx, NUM_REC);
      $display("TEST FAIL");
      $fatal(1, "missing stores");
    end
  end

endmodule

//--- src.f
source/rv32i_pkg.sv
source/pipe_pkg.sv
source/alu.sv
source/control_unit.sv
source/rv32i_reg_file.sv
source/fetch_stage.sv
source/execute_stage.sv
source/rv32i_core.sv
tb/tb_core.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_core -o tb_core_sim
	./obj_dir/tb_core_sim

clean:
	rm -rf obj_dir

//--- tb/program.hex
// One RV32I instruction word per line, from address 0 upward
// Comments give the instruction and the value it produces
00A00093 // 00 addi x1,x0,10       x1 = 10
FFD00113 // 04 addi x2,x0,-3       x2 = fffffffd
402081B3 // 08 sub  x3,x1,x2       x3 = 13
00302023 // 0c sw   x3,0(x0)       mem[0] = 0000000d
40115213 // 10 srai x4,x2,1        x4 = fffffffe
00402223 // 14 sw   x4,4(x0)
001122B3 // 18 slt  x5,x2,x1       x5 = 1
12345337 // 1c lui  x6,0x12345     x6 = 12345000
005343B3 // 20 xor  x7,x6,x5       x7 = 12345001
00702423 // 24 sw   x7,8(x0)
00001417 // 28 auipc x8,1          x8 = 00001028
00802623 // 2c sw   x8,12(x0)
001484B3 // 30 add  x9,x9,x1       sum of 10 down to 1
FFF08093 // 34 addi x1,x1,-1
FE009CE3 // 38 bne  x1,x0,-8       backward, predicted taken
00902823 // 3c sw   x9,16(x0)      mem[16] = 55
00114463 // 40 blt  x2,x1,+8       taken, predicted not taken
00102A23 // 44 sw   x1,20(x0)      skipped
00110463 // 48 beq  x2,x1,+8       not taken
00502A23 // 4c sw   x5,20(x0)      mem[20] = 1
00117463 // 50 bgeu x2,x1,+8       taken
00202A23 // 54 sw   x2,20(x0)      skipped
008005EF // 58 jal  x11,+8         x11 = 5c
00202A23 // 5c sw   x2,20(x0)      skipped
00B02C23 // 60 sw   x11,24(x0)
01158667 // 64 jalr x12,17(x11)    to 6c, x12 = 68
00202A23 // 68 sw   x2,20(x0)      skipped
00C02E23 // 6c sw   x12,28(x0)
022000A3 // 70 sb   x2,33(x0)      lane 1 = fd
02701323 // 74 sh   x7,38(x0)      lanes 3:2 = 5001
02100683 // 78 lb   x13,33(x0)     x13 = fffffffd
02104703 // 7c lbu  x14,33(x0)     x14 = fd
02601783 // 80 lh   x15,38(x0)     x15 = 5001
02D02423 // 84 sw   x13,40(x0)
02E02623 // 88 sw   x14,44(x0)
02F02823 // 8c sw   x15,48(x0)
00000000 // 90 halt marker
